//--- rtl/z8IsaPkg.sv
`default_nettype none

package z8IsaPkg;

    // two-operand codes equal the high nibble of the column 2 opcodes
    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_ADC = 4'h1,
        ALU_SUB = 4'h2,
        ALU_SBC = 4'h3,
        ALU_OR  = 4'h4,
        ALU_AND = 4'h5,
        ALU_TCM = 4'h6,
        ALU_TM  = 4'h7,
        ALU_CP  = 4'hA,
        ALU_XOR = 4'hB,
        ALU_INC = 4'hE,
        ALU_LD  = 4'hF
    } aluOp_t;

    // high nibble of jr and jp opcodes
    typedef enum logic [3:0] {
        COND_NEVER  = 4'h0,
        COND_LT     = 4'h1,
        COND_LE     = 4'h2,
        COND_ULE    = 4'h3,
        COND_OV     = 4'h4,
        COND_MI     = 4'h5,
        COND_Z      = 4'h6,
        COND_C      = 4'h7,
        COND_ALWAYS = 4'h8,
        COND_GE     = 4'h9,
        COND_GT     = 4'hA,
        COND_UGT    = 4'hB,
        COND_NOV    = 4'hC,
        COND_PL     = 4'hD,
        COND_NZ     = 4'hE,
        COND_NC     = 4'hF
    } cond_t;

    // opcode columns (low nibble) where the row is an operand or condition
    typedef enum logic [3:0] {
        COL_ALU2    = 4'h2,
        COL_LD_W_R  = 4'h8,
        COL_LD_R_W  = 4'h9,
        COL_JR      = 4'hB,
        COL_LD_W_IM = 4'hC,
        COL_JP      = 4'hD,
        COL_INC     = 4'hE,
        COL_MISC    = 4'hF
    } opColumn_t;

    typedef enum logic [7:0] {
        OP_SRP    = 8'h31,
        OP_LD_RR  = 8'hE4,
        OP_LD_RIM = 8'hE6,
        OP_RCF    = 8'hCF,
        OP_SCF    = 8'hDF,
        OP_CCF    = 8'hEF,
        OP_NOP    = 8'hFF
    } opcode_t;

    localparam int FLAG_C = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_S = 5;
    localparam int FLAG_V = 4;

    localparam logic [7:0] REG_PORT2 = 8'h02;
    localparam logic [7:0] REG_FLAGS = 8'hFC;
    localparam logic [7:0] REG_RP    = 8'hFD;

    localparam logic [15:0] PC_RESET = 16'h000C;

endpackage

`default_nettype wire

//--- rtl/z8BusPkg.sv
`default_nettype none

package z8BusPkg;

    typedef struct packed {
        logic [15:0] addr;
        logic        strobe;
    } memReq_t;

    // register write plus an optional FLAGS update from the same operation
    typedef struct packed {
        logic       en;
        logic [7:0] addr;
        logic [7:0] data;
        logic       flagsEn;
        logic [7:0] flagsData;
    } regWrite_t;

    typedef enum logic [3:0] {
        STATE_FETCH,
        STATE_READ_INSTR,
        STATE_WAIT2,
        STATE_READ2,
        STATE_WAIT3,
        STATE_READ3,
        STATE_DECODE,
        STATE_ALU_READ,
        STATE_ALU_WRITE,
        STATE_JUMP
    } coreState_t;

endpackage

`default_nettype wire

//--- rtl/programRom.sv
`timescale 1ns/1ps
`default_nettype none

module programRom #(
    parameter int romAddrWidth = 13
) (
    input  wire                    clk,
    input  wire z8BusPkg::memReq_t req,
    input  wire                    writeEn,
    input  wire [7:0]              writeData,
    output logic [7:0]             readData
);
    localparam int romSize = 1 << romAddrWidth;

    logic [7:0]              mem [romSize];
    logic [romAddrWidth-1:0] addr;

    // upper address bits ignored, so the ROM wraps
    assign addr = req.addr[romAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (req.strobe) begin
            if (writeEn) begin
                mem[addr] <= writeData;
            end else begin
                readData <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire [7:0]                rdAddrA,
    input  wire [7:0]                rdAddrB,
    input  wire z8BusPkg::regWrite_t wr,
    output logic [7:0]               rdDataA,
    output logic [7:0]               rdDataB,
    output logic [3:0]               rp,
    output logic [7:0]               flags,
    output logic [7:0]               port2,
    output logic                     port2Strobe
);
    import z8IsaPkg::*;

    logic [7:0] regs [128];

    function automatic logic [7:0] readReg(input logic [7:0] addr);
        if (!addr[7]) begin
            return regs[addr[6:0]];
        end else if (addr == REG_FLAGS) begin
            return flags;
        end else if (addr == REG_RP) begin
            return {rp, 4'h0};
        end
        // unimplemented control registers
        return 8'h00;
    endfunction

    always_comb begin
        rdDataA = readReg(rdAddrA);
        rdDataB = readReg(rdAddrB);
    end

    always_ff @(posedge clk) begin
        if (wr.en && !wr.addr[7]) begin
            regs[wr.addr[6:0]] <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rp          <= 4'h0;
            flags       <= 8'h00;
            port2       <= 8'h00;
            port2Strobe <= 1'b0;
        end else begin
            port2Strobe <= 1'b0;
            // explicit write to FC beats the flags from the ALU
            if (wr.en && wr.addr == REG_FLAGS) begin
                flags <= wr.data;
            end else if (wr.flagsEn) begin
                flags <= wr.flagsData;
            end
            if (wr.en && wr.addr == REG_RP) begin
                rp <= wr.data[7:4];
            end
            if (wr.en && wr.addr == REG_PORT2) begin
                port2       <= wr.data;
                port2Strobe <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire z8IsaPkg::aluOp_t op,
    input  wire [7:0]             a,
    input  wire [7:0]             b,
    input  wire [7:0]             flagsIn,
    output logic [7:0]            result,
    output logic [7:0]            flagsOut
);
    import z8IsaPkg::*;

    logic       isArith;
    logic       isLogic;
    logic       isSub;
    logic       carryIn;
    logic [8:0] sum;

    assign isArith = op inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP};
    assign isLogic = op inside {ALU_OR, ALU_AND, ALU_TCM, ALU_TM, ALU_XOR};
    assign isSub   = op inside {ALU_SUB, ALU_SBC, ALU_CP};
    assign carryIn = flagsIn[FLAG_C] && (op == ALU_ADC || op == ALU_SBC);

    // bit 8 is carry out, or borrow when subtracting
    assign sum = isSub ? {1'b0, a} - {1'b0, b} - {8'h00, carryIn}
                       : {1'b0, a} + {1'b0, b} + {8'h00, carryIn};

    always_comb begin
        result   = a;
        flagsOut = flagsIn;

        case (op)
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP: begin
                result = sum[7:0];
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_AND, ALU_TM: begin
                result = a & b;
            end
            ALU_TCM: begin
                result = ~a & b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_INC: begin
                result = a + 8'h01;
            end
            default: begin
                result = a;
            end
        endcase

        if (isArith || isLogic || op == ALU_INC) begin
            flagsOut[FLAG_Z] = result == 8'h00;
            flagsOut[FLAG_S] = result[7];
        end
        if (isArith) begin
            flagsOut[FLAG_C] = sum[8];
            // operand signs equal for add, differ for subtract
            flagsOut[FLAG_V] = ((a[7] ^ b[7]) == isSub) && (sum[7] != a[7]);
        end
        if (isLogic) begin
            flagsOut[FLAG_V] = 1'b0;
        end
        if (op == ALU_INC) begin
            flagsOut[FLAG_V] = a == 8'h7F;
        end
    end

endmodule

`default_nettype wire

//--- rtl/z8Core.sv
`timescale 1ns/1ps
`default_nettype none

module z8Core (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire [7:0]           romData,
    input  wire [3:0]           rp,
    input  wire [7:0]           flags,
    input  wire [7:0]           rdDataA,
    input  wire [7:0]           rdDataB,
    input  wire [7:0]           aluResult,
    input  wire [7:0]           aluFlags,
    output z8BusPkg::memReq_t   memReq,
    output logic [7:0]          rdAddrA,
    output logic [7:0]          rdAddrB,
    output z8IsaPkg::aluOp_t    aluOp,
    output logic [7:0]          aluA,
    output logic [7:0]          aluB,
    output z8BusPkg::regWrite_t regWr
);
    import z8IsaPkg::*;
    import z8BusPkg::*;

    coreState_t  state;
    logic [15:0] pc;
    logic [7:0]  instruction;
    logic [7:0]  second;
    logic [7:0]  third;
    logic [7:0]  opA;
    logic [7:0]  opB;

    logic [3:0]  instrH;
    logic [3:0]  instrL;
    logic        isSize1;
    logic        isSize2;
    logic        isSize3;
    logic        isAlu2;
    logic        isInc;
    logic        isLoad;
    logic        taken;
    logic        writesResult;
    aluOp_t      aluFunc;
    logic [7:0]  regDst;
    logic [7:0]  regSrc;
    logic [7:0]  loadValue;

    // Ex addresses select working registers
    function automatic logic [7:0] r8(input logic [7:0] addr);
        return (addr[7:4] == 4'hE) ? {rp, addr[3:0]} : addr;
    endfunction

    function automatic logic condTrue(input cond_t cc, input logic [7:0] f);
        logic base;
        case (cc)
            COND_NEVER, COND_ALWAYS: base = 1'b0;
            COND_LT, COND_GE:        base = f[FLAG_S] ^ f[FLAG_V];
            COND_LE, COND_GT:        base = (f[FLAG_S] ^ f[FLAG_V]) | f[FLAG_Z];
            COND_ULE, COND_UGT:      base = f[FLAG_C] | f[FLAG_Z];
            COND_OV, COND_NOV:       base = f[FLAG_V];
            COND_MI, COND_PL:        base = f[FLAG_S];
            COND_Z, COND_NZ:         base = f[FLAG_Z];
            COND_C, COND_NC:         base = f[FLAG_C];
            default:                 base = 1'b0;
        endcase
        // upper half of the table negates the lower half
        return base ^ cc[3];
    endfunction

    assign instrH  = instruction[7:4];
    assign instrL  = instruction[3:0];
    assign isSize1 = instrL[3:1] == 3'b111;
    // call @IRR (D4) stays two bytes
    assign isSize3 = (instrL[3:2] == 2'b01 || instrL == COL_JP) && instruction != 8'hD4;
    assign isSize2 = !isSize1 && !isSize3;

    assign isAlu2 = instrL == COL_ALU2 && (!instrH[3] || instrH[3:1] == 3'b101);
    assign isInc  = instrL == COL_INC;
    assign isLoad = instrL inside {COL_LD_W_IM, COL_LD_W_R, COL_LD_R_W}
                 || instruction inside {OP_LD_RR, OP_LD_RIM, OP_SRP};
    assign taken  = condTrue(cond_t'(instrH), flags);

    assign aluFunc      = isInc ? ALU_INC : aluOp_t'(instrH);
    assign writesResult = !(aluFunc inside {ALU_CP, ALU_TM});

    always_comb begin
        regDst    = {rp, instrH};
        regSrc    = r8(second);
        loadValue = rdDataB;
        case (instrL)
            COL_ALU2: begin
                regDst = {rp, second[7:4]};
                regSrc = {rp, second[3:0]};
            end
            COL_LD_R_W: begin
                // destination taken as is, no working register mapping
                regDst = second;
                regSrc = {rp, instrH};
            end
            COL_LD_W_IM: begin
                loadValue = second;
            end
            default: begin
            end
        endcase
        case (instruction)
            OP_LD_RR: begin
                regDst = r8(third);
            end
            OP_LD_RIM: begin
                regDst    = r8(second);
                loadValue = third;
            end
            OP_SRP: begin
                regDst    = REG_RP;
                loadValue = second;
            end
            default: begin
            end
        endcase
    end

    assign rdAddrA = regDst;
    assign rdAddrB = regSrc;

    always_comb begin
        memReq.addr   = pc;
        memReq.strobe = state == STATE_FETCH
                     || (state == STATE_WAIT2 && !isSize1)
                     || state == STATE_WAIT3;
    end

    always_comb begin
        aluOp = aluFunc;
        aluA  = opA;
        aluB  = opB;
        regWr = '0;
        if (state == STATE_DECODE) begin
            // moves pass through the ALU unchanged
            aluOp           = ALU_LD;
            aluA            = loadValue;
            regWr.en        = isLoad;
            regWr.addr      = regDst;
            regWr.data      = aluResult;
            regWr.flagsData = flags;
            case (instruction)
                OP_RCF: begin
                    regWr.flagsEn           = 1'b1;
                    regWr.flagsData[FLAG_C] = 1'b0;
                end
                OP_SCF: begin
                    regWr.flagsEn           = 1'b1;
                    regWr.flagsData[FLAG_C] = 1'b1;
                end
                OP_CCF: begin
                    regWr.flagsEn           = 1'b1;
                    regWr.flagsData[FLAG_C] = !flags[FLAG_C];
                end
                default: begin
                end
            endcase
        end else if (state == STATE_ALU_WRITE) begin
            regWr.en        = writesResult;
            regWr.addr      = regDst;
            regWr.data      = aluResult;
            regWr.flagsEn   = 1'b1;
            regWr.flagsData = aluFlags;
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            STATE_READ_INSTR: instruction <= romData;
            STATE_READ2:      second <= romData;
            STATE_READ3:      third <= romData;
            STATE_ALU_READ: begin
                opA <= rdDataA;
                opB <= rdDataB;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= STATE_FETCH;
            pc    <= PC_RESET;
        end else begin
            case (state)
                STATE_FETCH: begin
                    state <= STATE_READ_INSTR;
                end
                STATE_READ_INSTR: begin
                    pc    <= pc + 16'd1;
                    state <= STATE_WAIT2;
                end
                STATE_WAIT2: begin
                    state <= isSize1 ? STATE_DECODE : STATE_READ2;
                end
                STATE_READ2: begin
                    pc    <= pc + 16'd1;
                    state <= isSize2 ? STATE_DECODE : STATE_WAIT3;
                end
                STATE_WAIT3: begin
                    state <= STATE_READ3;
                end
                STATE_READ3: begin
                    pc    <= pc + 16'd1;
                    state <= STATE_DECODE;
                end
                STATE_DECODE: begin
                    if (isAlu2 || isInc) begin
                        state <= STATE_ALU_READ;
                    end else if (instrL == COL_JP && taken) begin
                        state <= STATE_JUMP;
                    end else begin
                        state <= STATE_FETCH;
                    end
                    // pc already points past the jr
                    if (instrL == COL_JR && taken) begin
                        pc <= pc + {{8{second[7]}}, second};
                    end
                end
                STATE_ALU_READ: begin
                    state <= STATE_ALU_WRITE;
                end
                STATE_JUMP: begin
                    pc    <= {second, third};
                    state <= STATE_FETCH;
                end
                default: begin
                    state <= STATE_FETCH;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/z8Soc.sv
`timescale 1ns/1ps
`default_nettype none

module z8Soc #(
    parameter int romAddrWidth = 13
) (
    input  wire        clk,
    input  wire        rstN,
    input  wire        loadStrobe,
    input  wire [15:0] loadAddr,
    input  wire [7:0]  loadData,
    output logic [7:0] port2,
    output logic       port2Strobe
);
    import z8IsaPkg::*;
    import z8BusPkg::*;

    memReq_t    coreReq;
    memReq_t    romReq;
    logic       romWriteEn;
    logic [7:0] romData;
    regWrite_t  regWr;
    logic [7:0] rdAddrA;
    logic [7:0] rdAddrB;
    logic [7:0] rdDataA;
    logic [7:0] rdDataB;
    logic [3:0] rp;
    logic [7:0] flags;
    aluOp_t     aluOp;
    logic [7:0] aluA;
    logic [7:0] aluB;
    logic [7:0] aluResult;
    logic [7:0] aluFlags;

    // program loading owns the ROM port while the core sits in reset
    always_comb begin
        if (rstN) begin
            romReq = coreReq;
        end else begin
            romReq.addr   = loadAddr;
            romReq.strobe = loadStrobe;
        end
    end

    assign romWriteEn = !rstN && loadStrobe;

    programRom #(
        .romAddrWidth(romAddrWidth)
    ) rom (
        .clk      (clk),
        .req      (romReq),
        .writeEn  (romWriteEn),
        .writeData(loadData),
        .readData (romData)
    );

    registerFile regFile (
        .clk        (clk),
        .rstN       (rstN),
        .rdAddrA    (rdAddrA),
        .rdAddrB    (rdAddrB),
        .wr         (regWr),
        .rdDataA    (rdDataA),
        .rdDataB    (rdDataB),
        .rp         (rp),
        .flags      (flags),
        .port2      (port2),
        .port2Strobe(port2Strobe)
    );

    alu aluUnit (
        .op      (aluOp),
        .a       (aluA),
        .b       (aluB),
        .flagsIn (flags),
        .result  (aluResult),
        .flagsOut(aluFlags)
    );

    z8Core core (
        .clk      (clk),
        .rstN     (rstN),
        .romData  (romData),
        .rp       (rp),
        .flags    (flags),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .aluResult(aluResult),
        .aluFlags (aluFlags),
        .memReq   (coreReq),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .aluOp    (aluOp),
        .aluA     (aluA),
        .aluB     (aluB),
        .regWr    (regWr)
    );

endmodule

`default_nettype wire

//--- tests/z8Soc_props.sv
`timescale 1ns/1ps
`default_nettype none

module z8CoreProps (
    input wire                      clk,
    input wire                      rstN,
    input wire z8BusPkg::coreState_t state,
    input wire z8BusPkg::memReq_t    memReq,
    input wire z8BusPkg::regWrite_t  regWr
);
    import z8BusPkg::*;

    // decode only works on bytes already fetched
    noRomInDecode: assert property (@(posedge clk) disable iff (!rstN)
        state == STATE_DECODE |-> !memReq.strobe)
        else $error("ROM strobe high in the decode state");

    writeStates: assert property (@(posedge clk) disable iff (!rstN)
        (regWr.en || regWr.flagsEn) |-> state inside {STATE_DECODE, STATE_ALU_WRITE})
        else $error("register write outside decode and aluWrite");

    fetchInReset: assert property (@(posedge clk)
        !rstN |=> state == STATE_FETCH)
        else $error("core state is not fetch during reset");

endmodule

bind z8Core z8CoreProps props (
    .clk   (clk),
    .rstN  (rstN),
    .state (state),
    .memReq(memReq),
    .regWr (regWr)
);

`default_nettype wire

//--- tests/z8SocTb.sv
`timescale 1ns/1ps
`default_nettype none

module z8SocTb;
    import z8IsaPkg::*;

    logic        clk;
    logic        rstN;
    logic        loadStrobe;
    logic [15:0] loadAddr;
    logic [7:0]  loadData;
    logic [7:0]  port2;
    logic        port2Strobe;

    integer     seed;
    logic [7:0] prog [2048];
    int         genPc;
    int         numInstr;
    logic [7:0] mRegs [128];
    logic [3:0] mRp;
    logic [7:0] mFlags;
    logic [7:0] expectQ [$];
    int         expectTotal;
    int         seenCount;
    int         valueErrors;
    int         otherErrors;
    int         watchdogNs;
    logic       programReady;

    z8Soc #(
        .romAddrWidth(13)
    ) z8Soc_inst (
        .clk        (clk),
        .rstN       (rstN),
        .loadStrobe (loadStrobe),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .port2      (port2),
        .port2Strobe(port2Strobe)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [3:0] randNibble();
        return $random(seed);
    endfunction

    function automatic int randBelow(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [7:0] resolveAddr(input logic [7:0] a);
        if (a[7:4] == 4'hE) begin
            return {mRp, a[3:0]};
        end
        return a;
    endfunction

    function automatic logic [7:0] readModel(input logic [7:0] a);
        if (a < 8'h80) begin
            return mRegs[a[6:0]];
        end else if (a == REG_FLAGS) begin
            return mFlags;
        end else if (a == REG_RP) begin
            return {mRp, 4'h0};
        end
        return 8'h00;
    endfunction

    function automatic logic condModel(input cond_t cc);
        logic c;
        logic z;
        logic s;
        logic v;
        c = mFlags[FLAG_C];
        z = mFlags[FLAG_Z];
        s = mFlags[FLAG_S];
        v = mFlags[FLAG_V];
        case (cc)
            COND_NEVER:  return 1'b0;
            COND_LT:     return s ^ v;
            COND_LE:     return (s ^ v) | z;
            COND_ULE:    return c | z;
            COND_OV:     return v;
            COND_MI:     return s;
            COND_Z:      return z;
            COND_C:      return c;
            COND_ALWAYS: return 1'b1;
            COND_GE:     return !(s ^ v);
            COND_GT:     return !((s ^ v) | z);
            COND_UGT:    return !(c | z);
            COND_NOV:    return !v;
            COND_PL:     return !s;
            COND_NZ:     return !z;
            default:     return !c;
        endcase
    endfunction

    task automatic emit(input logic [7:0] b);
        prog[genPc] = b;
        genPc++;
    endtask

    task automatic writeModel(input logic [7:0] a, input logic [7:0] d);
        if (a < 8'h80) begin
            mRegs[a[6:0]] = d;
        end
        if (a == REG_PORT2) begin
            expectQ.push_back(d);
            expectTotal++;
        end
        if (a == REG_RP) begin
            mRp = d[7:4];
        end
    endtask

    task automatic aluModel(input aluOp_t op, input logic [7:0] a, input logic [7:0] b,
                            output logic [7:0] res);
        int   wide;
        logic cin;
        logic c;
        logic v;
        c   = mFlags[FLAG_C];
        v   = 1'b0;
        cin = (op == ALU_ADC || op == ALU_SBC) ? mFlags[FLAG_C] : 1'b0;
        case (op)
            ALU_ADD, ALU_ADC: begin
                wide = int'(a) + int'(b) + int'(cin);
                res  = wide[7:0];
                c    = wide > 255;
                v    = (a[7] == b[7]) && (res[7] != a[7]);
            end
            ALU_SUB, ALU_SBC, ALU_CP: begin
                wide = int'(a) - int'(b) - int'(cin);
                res  = wide[7:0];
                c    = wide < 0;
                v    = (a[7] != b[7]) && (res[7] != a[7]);
            end
            ALU_OR:  res = a | b;
            ALU_TCM: res = ~a & b;
            ALU_XOR: res = a ^ b;
            ALU_INC: begin
                res = a + 8'h01;
                v   = a == 8'h7F;
            end
            default: res = a & b;
        endcase
        mFlags = {c, res == 8'h00, res[7], v, 4'h0};
    endtask

    task automatic ldRegImm(input logic [7:0] dst, input logic [7:0] imm, input logic exec);
        emit(OP_LD_RIM);
        emit(dst);
        emit(imm);
        numInstr++;
        if (exec) begin
            writeModel(resolveAddr(dst), imm);
        end
    endtask

    task automatic ldRegReg(input logic [7:0] dst, input logic [7:0] src);
        emit(OP_LD_RR);
        emit(src);
        emit(dst);
        numInstr++;
        writeModel(resolveAddr(dst), readModel(resolveAddr(src)));
    endtask

    task automatic ldWorkImm(input logic [3:0] n, input logic [7:0] imm);
        emit({n, 4'hC});
        emit(imm);
        numInstr++;
        writeModel({mRp, n}, imm);
    endtask

    task automatic ldWorkReg(input logic [3:0] n, input logic [7:0] src);
        emit({n, 4'h8});
        emit(src);
        numInstr++;
        writeModel({mRp, n}, readModel(resolveAddr(src)));
    endtask

    // destination is a plain 8-bit address here
    task automatic ldRegWork(input logic [7:0] dst, input logic [3:0] n);
        emit({n, 4'h9});
        emit(dst);
        numInstr++;
        writeModel(dst, readModel({mRp, n}));
    endtask

    task automatic setPointer(input logic [3:0] rpNew);
        emit(OP_SRP);
        emit({rpNew, 4'h0});
        numInstr++;
        writeModel(REG_RP, {rpNew, 4'h0});
    endtask

    task automatic aluWork(input aluOp_t op, input logic [3:0] d, input logic [3:0] s);
        logic [7:0] res;
        emit({op, 4'h2});
        emit({d, s});
        numInstr++;
        aluModel(op, readModel({mRp, d}), readModel({mRp, s}), res);
        if (op != ALU_CP && op != ALU_TM) begin
            writeModel({mRp, d}, res);
        end
    endtask

    task automatic incWork(input logic [3:0] n);
        logic [7:0] res;
        emit({n, 4'hE});
        numInstr++;
        aluModel(ALU_INC, readModel({mRp, n}), 8'h00, res);
        writeModel({mRp, n}, res);
    endtask

    task automatic carryOp(input int kind);
        numInstr++;
        if (kind == 0) begin
            emit(OP_RCF);
            mFlags[FLAG_C] = 1'b0;
        end else if (kind == 1) begin
            emit(OP_SCF);
            mFlags[FLAG_C] = 1'b1;
        end else if (kind == 2) begin
            emit(OP_CCF);
            mFlags[FLAG_C] = !mFlags[FLAG_C];
        end else begin
            emit(OP_NOP);
        end
    endtask

    // marker load of 3 bytes sits right after the branch
    task automatic jrOverMarker(input cond_t cc);
        emit({cc, 4'hB});
        emit(8'h03);
        numInstr++;
        ldRegImm(REG_PORT2, $random(seed), !condModel(cc));
    endtask

    task automatic jpOverMarker(input cond_t cc);
        logic [15:0] target;
        target = genPc + 6;
        emit({cc, 4'hD});
        emit(target[15:8]);
        emit(target[7:0]);
        numInstr++;
        ldRegImm(REG_PORT2, $random(seed), !condModel(cc));
    endtask

    task automatic buildBlock(input int kind);
        logic [3:0] n;
        logic [3:0] m;
        logic [3:0] k;
        logic [7:0] v;
        n = randNibble();
        m = randNibble();
        k = randBelow(10);
        v = $random(seed);
        case (kind)
            0: begin
                ldWorkImm(n, v);
                ldRegWork(REG_PORT2, n);
            end
            1: ldRegImm(REG_PORT2, v, 1'b1);
            2: ldRegReg(REG_PORT2, 8'h10 + randBelow(48));
            3: begin
                // cp and xor codes sit above the gap at 8 and 9
                aluWork(aluOp_t'(k < 8 ? k : k + 2), n, m);
                ldRegWork(REG_PORT2, n);
                jrOverMarker(cond_t'(randNibble()));
            end
            4: begin
                carryOp(randBelow(4));
                jrOverMarker(cond_t'(randNibble()));
                aluWork(randBelow(2) ? ALU_ADC : ALU_SBC, n, m);
                ldRegWork(REG_PORT2, n);
            end
            5: begin
                setPointer(1 + randBelow(3));
                ldWorkImm(n, v);
                if (randBelow(2)) begin
                    ldRegReg(REG_PORT2, {4'hE, n});
                end else begin
                    ldWorkReg(m, {mRp, n});
                    ldRegWork(REG_PORT2, m);
                end
            end
            6: jpOverMarker(cond_t'(randNibble()));
            7: begin
                ldWorkImm(n, randBelow(3) == 0 ? v : (randBelow(2) ? 8'h7F : 8'hFF));
                incWork(n);
                ldRegWork(REG_PORT2, n);
                jrOverMarker(cond_t'(randNibble()));
            end
            default: begin
                ldRegWork(8'h10 + randBelow(48), n);
                carryOp(3);
            end
        endcase
    endtask

    task automatic buildProgram();
        genPc       = PC_RESET;
        numInstr    = 0;
        mRp         = 4'h0;
        mFlags      = 8'h00;
        expectTotal = 0;
        for (int a = 8'h10; a < 8'h40; a++) begin
            ldRegImm(a, $random(seed), 1'b1);
        end
        setPointer(4'h1);
        for (int i = 0; i < 90; i++) begin
            buildBlock(randBelow(9));
        end
        // park on a jr to itself
        emit({COND_ALWAYS, 4'hB});
        emit(8'hFE);
        numInstr++;
    endtask

    task automatic checkPort(input logic [7:0] actual, input logic [7:0] expected);
        if (actual !== expected) begin
            valueErrors++;
            $display("FAILED port2: got %h expected %h at %0t", actual, expected, $time);
        end
    endtask

    task automatic checkCount(input int actual, input int expected);
        if (actual != expected) begin
            valueErrors++;
            $display("FAILED port2Strobe count: got %h expected %h", actual, expected);
        end
    endtask

    task automatic endSimulation();
        $display("port2 writes seen %0d of %0d, value errors %0d, other errors %0d",
                 seenCount, expectTotal, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rstN) begin
            if (port2Strobe === 1'b1) begin
                if (expectQ.size() == 0) begin
                    otherErrors++;
                    $display("ERROR: port2 strobe with no write left in the model");
                end else begin
                    checkPort(port2, expectQ.pop_front());
                end
                seenCount++;
            end else if (port2Strobe !== 1'b0) begin
                otherErrors++;
                $display("ERROR: port2Strobe is unknown at %0t", $time);
            end else if (seenCount == 0) begin
                checkPort(port2, 8'h00);
            end
        end
    end

    initial begin
        wait (programReady);
        #(watchdogNs);
        otherErrors++;
        $display("ERROR: timeout, the program did not finish within %0d ns", watchdogNs);
        endSimulation();
    end

    initial begin
        rstN         = 1'b0;
        loadStrobe   = 1'b0;
        loadAddr     = 16'h0000;
        loadData     = 8'h00;
        seenCount    = 0;
        valueErrors  = 0;
        otherErrors  = 0;
        programReady = 1'b0;
        seed         = 32'hd7dc_7aa8;
        buildProgram();
        watchdogNs   = numInstr * 12 * 4 + (genPc + 60) * 4;
        programReady = 1'b1;

        // one ROM byte per cycle while the core is held in reset
        for (int a = PC_RESET; a < genPc; a++) begin
            @(posedge clk);
            #1;
            loadStrobe = 1'b1;
            loadAddr   = a;
            loadData   = prog[a];
        end
        @(posedge clk);
        #1;
        loadStrobe = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;

        wait (seenCount == expectTotal);
        // the core now spins on its last jr so any later strobe is stray
        repeat (30) @(posedge clk);
        checkCount(seenCount, expectTotal);
        endSimulation();
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/z8IsaPkg.sv
rtl/z8BusPkg.sv
rtl/programRom.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/z8Core.sv
rtl/z8Soc.sv
tests/z8Soc_props.sv
tests/z8SocTb.sv
